//--- source/gcu_pkg.sv
package gcu_pkg;

    // cpu and ram data word
    typedef logic [15:0] word_t;

    // video ram address, 8k words
    typedef logic [12:0] vram_addr_t;

    // cpu pointer; only the low bits reach the ram
    typedef logic [15:0] ram_ptr_t;

    // selected register number, stored as din & 0x8f
    typedef logic [7:0] reg_num_t;

    // sprite ram is split in four banks
    typedef logic [1:0] bank_idx_t;

    // bank index in the top bits, word offset below
    typedef logic [11:0] sprite_addr_t;

    // ram read sequence, also used for the two-step write
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_WAIT,
        RD_DONE
    } read_state_e;

    // sprite window inside the vram address space
    localparam vram_addr_t SPRITE_WIN_BASE = 13'h1800;
    localparam int SPRITE_WIN_WORDS = 1024;

    // x and y for each of bg, fg, text, sprite
    localparam int SCROLL_REG_COUNT = 8;

endpackage

//--- source/gcu_bus_ctrl.sv
`timescale 1ns/100ps

module gcu_bus_ctrl #(
    parameter int VRAM_AW = 13
) (
    input  logic               CLK96,
    input  logic               RESET96,
    input  gcu_pkg::word_t     din,
    input  logic               op_select_reg,
    input  logic               op_write_reg,
    input  logic               op_set_ram_ptr,
    input  logic               op_write_ram,
    input  logic               op_read_ram_h,
    input  logic               op_read_ram_l,
    input  gcu_pkg::word_t     ram_rdata,
    output gcu_pkg::word_t     dout,
    output logic               ack,
    output logic               ram_we,
    output gcu_pkg::vram_addr_t ram_addr,
    output gcu_pkg::word_t     ram_din,
    output gcu_pkg::word_t     bg_scroll_x,
    output gcu_pkg::word_t     bg_scroll_y,
    output gcu_pkg::word_t     fg_scroll_x,
    output gcu_pkg::word_t     fg_scroll_y,
    output gcu_pkg::word_t     txt_scroll_x,
    output gcu_pkg::word_t     txt_scroll_y,
    output gcu_pkg::word_t     spr_scroll_x,
    output gcu_pkg::word_t     spr_scroll_y
);

    gcu_pkg::reg_num_t      reg_num;
    gcu_pkg::ram_ptr_t      ptr;
    gcu_pkg::word_t         scroll_q [gcu_pkg::SCROLL_REG_COUNT];
    gcu_pkg::read_state_e   state;
    gcu_pkg::read_state_e   cur_state;
    gcu_pkg::vram_addr_t    ptr_lo;
    logic [5:0]             op_vec;
    logic [5:0]             last_op;
    logic                   op_changed;
    logic                   rd_low;
    logic                   reg_valid;
    logic                   do_sel;
    logic                   do_wreg;
    logic                   do_ptr;
    logic                   do_wstart;
    logic                   do_rstart;
    logic                   do_rdone;

    assign op_vec = {op_select_reg, op_write_reg, op_set_ram_ptr,
                     op_write_ram, op_read_ram_h, op_read_ram_l};
    assign op_changed = (op_vec != last_op);

    // any change in the strobe set restarts the sequence
    assign cur_state = op_changed ? gcu_pkg::RD_IDLE : state;

    assign ptr_lo = gcu_pkg::vram_addr_t'(ptr[VRAM_AW-1:0]);
    // read_h wins when both read strobes are up
    assign rd_low = op_read_ram_l && !op_read_ram_h;
    assign reg_valid = (reg_num & 8'h7f) < 8'(gcu_pkg::SCROLL_REG_COUNT);

    // strobe priority; the second write cycle blocks everything else
    always_comb begin
        do_sel    = 1'b0;
        do_wreg   = 1'b0;
        do_ptr    = 1'b0;
        do_wstart = 1'b0;
        do_rstart = 1'b0;
        do_rdone  = 1'b0;
        if (!ram_we) begin
            if (op_select_reg) begin
                do_sel = 1'b1;
            end else if (op_write_reg) begin
                do_wreg = 1'b1;
            end else if (op_set_ram_ptr) begin
                do_ptr = 1'b1;
            end else if (op_write_ram) begin
                do_wstart = (cur_state == gcu_pkg::RD_IDLE);
            end else if (op_read_ram_h || op_read_ram_l) begin
                do_rstart = (cur_state == gcu_pkg::RD_IDLE);
                do_rdone  = (cur_state == gcu_pkg::RD_WAIT);
            end
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            ack     <= 1'b1;
            ram_we  <= 1'b0;
            reg_num <= 8'hff;
            ptr     <= '0;
            last_op <= '0;
            state   <= gcu_pkg::RD_IDLE;
            for (int i = 0; i < gcu_pkg::SCROLL_REG_COUNT; i++) begin
                scroll_q[i] <= '0;
            end
        end else begin
            last_op <= op_vec;
            if (ram_we) begin
                // second write cycle always completes
                ram_we <= 1'b0;
                ptr    <= ptr + 16'd1;
                ack    <= 1'b1;
                state  <= op_changed ? gcu_pkg::RD_IDLE : gcu_pkg::RD_DONE;
            end else if (do_sel) begin
                reg_num <= din[7:0] & 8'h8f;
                ack     <= 1'b1;
                state   <= gcu_pkg::RD_IDLE;
            end else if (do_wreg) begin
                if (reg_valid) begin
                    scroll_q[reg_num[2:0]] <= din;
                end
                ack   <= 1'b1;
                state <= gcu_pkg::RD_IDLE;
            end else if (do_ptr) begin
                ptr   <= din;
                ack   <= 1'b1;
                state <= gcu_pkg::RD_IDLE;
            end else if (op_write_ram) begin
                if (do_wstart) begin
                    ram_we <= 1'b1;
                    ack    <= 1'b0;
                    state  <= gcu_pkg::RD_ADDR;
                end
            end else if (op_read_ram_h || op_read_ram_l) begin
                case (cur_state)
                    gcu_pkg::RD_IDLE: begin
                        ack   <= 1'b0;
                        state <= gcu_pkg::RD_ADDR;
                    end
                    // ram output registers during this cycle
                    gcu_pkg::RD_ADDR: state <= gcu_pkg::RD_WAIT;
                    gcu_pkg::RD_WAIT: begin
                        ack   <= 1'b1;
                        state <= gcu_pkg::RD_DONE;
                    end
                    default: state <= gcu_pkg::RD_DONE;
                endcase
            end else begin
                ack   <= 1'b1;
                state <= gcu_pkg::RD_IDLE;
            end
        end
    end

    // ram port and read data
    always_ff @(posedge CLK96) begin
        if (do_wstart) begin
            ram_addr <= ptr_lo;
            ram_din  <= din;
        end else if (do_rstart) begin
            ram_addr <= ptr_lo + gcu_pkg::vram_addr_t'(rd_low);
        end
        if (do_rdone) begin
            dout <= ram_rdata;
        end
    end

    assign bg_scroll_x  = scroll_q[0];
    assign bg_scroll_y  = scroll_q[1];
    assign fg_scroll_x  = scroll_q[2];
    assign fg_scroll_y  = scroll_q[3];
    assign txt_scroll_x = scroll_q[4];
    assign txt_scroll_y = scroll_q[5];
    assign spr_scroll_x = scroll_q[6];
    assign spr_scroll_y = scroll_q[7];

    // each write strobes the ram for a single cycle
    a_we_single: assert property (@(posedge CLK96) disable iff (RESET96)
        ram_we |=> !ram_we)
        else $error("ram_we held high for two cycles");

endmodule

//--- source/gcu_sprite_bank_ctrl.sv
`timescale 1ns/100ps

module gcu_sprite_bank_ctrl #(
    parameter int SPRITE_BANK_WORDS = 1024
) (
    input  logic                  CLK96,
    input  logic                  RESET96,
    input  logic                  lvbl,
    output gcu_pkg::bank_idx_t    wr_bank,
    output gcu_pkg::bank_idx_t    rd_bank,
    output logic                  clearing,
    output gcu_pkg::sprite_addr_t clear_addr
);

    localparam int OFS_W = $clog2(SPRITE_BANK_WORDS);

    logic                 lvbl_q;
    logic                 lvbl_rise;
    logic [OFS_W-1:0]     clear_cnt;
    gcu_pkg::bank_idx_t   clr_bank;

    assign lvbl_rise = lvbl && !lvbl_q;

    // bank written next gets swept while the cpu fills wr_bank
    assign clr_bank = wr_bank + 2'd1;
    // renderer stays two frames behind the cpu
    assign rd_bank  = wr_bank + 2'd2;

    assign clear_addr = gcu_pkg::sprite_addr_t'({clr_bank, clear_cnt});

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            lvbl_q    <= 1'b0;
            wr_bank   <= '0;
            clearing  <= 1'b0;
            clear_cnt <= '0;
        end else begin
            lvbl_q <= lvbl;
            if (lvbl_rise) begin
                wr_bank   <= wr_bank + 2'd1;
                clearing  <= 1'b1;
                clear_cnt <= '0;
            end else if (clearing) begin
                // one word per cycle, stop after the last one
                if (clear_cnt == OFS_W'(SPRITE_BANK_WORDS - 1)) begin
                    clearing <= 1'b0;
                end
                clear_cnt <= clear_cnt + 1'b1;
            end
        end
    end

    a_clear_in_bank: assert property (@(posedge CLK96) disable iff (RESET96)
        clearing |-> (int'(clear_addr) / SPRITE_BANK_WORDS) ==
                     int'(gcu_pkg::bank_idx_t'(wr_bank + 2'd1)))
        else $error("clear sweep left bank wr_bank+1");

endmodule

//--- source/gcu_vram.sv
`timescale 1ns/100ps

module gcu_vram #(
    parameter int VRAM_AW           = 13,
    parameter int SPRITE_BANK_WORDS = 1024
) (
    input  logic                                 CLK96,
    input  logic                                 ram_we,
    input  gcu_pkg::vram_addr_t                  ram_addr,
    input  gcu_pkg::word_t                       ram_din,
    input  gcu_pkg::bank_idx_t                   wr_bank,
    input  gcu_pkg::bank_idx_t                   rd_bank,
    input  logic                                 clearing,
    input  gcu_pkg::sprite_addr_t                clear_addr,
    input  logic [$clog2(SPRITE_BANK_WORDS)-1:0] sprite_rd_addr,
    output gcu_pkg::word_t                       ram_rdata,
    output gcu_pkg::word_t                       sprite_rd_data
);

    localparam int OFS_W = $clog2(SPRITE_BANK_WORDS);

    gcu_pkg::word_t        main_mem   [2**VRAM_AW];
    gcu_pkg::word_t        sprite_mem [4*SPRITE_BANK_WORDS];

    gcu_pkg::vram_addr_t   win_off;
    gcu_pkg::sprite_addr_t spr_wr_addr;
    gcu_pkg::sprite_addr_t spr_rd_addr;
    logic                  in_win;
    logic                  spr_we;

    // sprite window decode
    assign in_win = (ram_addr >= gcu_pkg::SPRITE_WIN_BASE) &&
                    (int'(ram_addr) < int'(gcu_pkg::SPRITE_WIN_BASE) + gcu_pkg::SPRITE_WIN_WORDS);
    assign win_off = ram_addr - gcu_pkg::SPRITE_WIN_BASE;
    assign spr_we  = ram_we && in_win;

    // bank base is bank index times the bank size
    assign spr_wr_addr = gcu_pkg::sprite_addr_t'({wr_bank, win_off[OFS_W-1:0]});
    assign spr_rd_addr = gcu_pkg::sprite_addr_t'({rd_bank, sprite_rd_addr});

    // main ram, one cycle read latency
    always_ff @(posedge CLK96) begin
        if (ram_we) begin
            main_mem[ram_addr] <= ram_din;
        end
        ram_rdata <= main_mem[ram_addr];
    end

    // port a takes cpu writes into the sprite window
    // port b is shared by the clear sweep and the renderer
    always_ff @(posedge CLK96) begin
        if (spr_we) begin
            sprite_mem[spr_wr_addr] <= ram_din;
        end
        if (clearing) begin
            sprite_mem[clear_addr] <= '0;
        end else begin
            sprite_rd_data <= sprite_mem[spr_rd_addr];
        end
    end

    // cpu write bank and sweep bank must differ
    a_no_bank_clash: assert property (@(posedge CLK96)
        (spr_we && clearing) |->
            (int'(spr_wr_addr) / SPRITE_BANK_WORDS) != (int'(clear_addr) / SPRITE_BANK_WORDS))
        else $error("sprite write and clear hit the same bank");

endmodule

//--- source/gcu_top.sv
`timescale 1ns/100ps

module gcu_top #(
    parameter int VRAM_AW           = 13,
    parameter int SPRITE_BANK_WORDS = 1024
) (
    input  logic                                 CLK96,
    input  logic                                 RESET96,
    input  logic                                 lvbl,
    input  logic [$clog2(SPRITE_BANK_WORDS)-1:0] sprite_rd_addr,
    output gcu_pkg::word_t                       sprite_rd_data,
    input  gcu_pkg::word_t                       din,
    input  logic                                 op_select_reg,
    input  logic                                 op_write_reg,
    input  logic                                 op_set_ram_ptr,
    input  logic                                 op_write_ram,
    input  logic                                 op_read_ram_h,
    input  logic                                 op_read_ram_l,
    output gcu_pkg::word_t                       dout,
    output logic                                 ack,
    output gcu_pkg::word_t                       bg_scroll_x,
    output gcu_pkg::word_t                       bg_scroll_y,
    output gcu_pkg::word_t                       fg_scroll_x,
    output gcu_pkg::word_t                       fg_scroll_y,
    output gcu_pkg::word_t                       txt_scroll_x,
    output gcu_pkg::word_t                       txt_scroll_y,
    output gcu_pkg::word_t                       spr_scroll_x,
    output gcu_pkg::word_t                       spr_scroll_y
);

    logic                  ram_we;
    gcu_pkg::vram_addr_t   ram_addr;
    gcu_pkg::word_t        ram_din;
    gcu_pkg::word_t        ram_rdata;
    gcu_pkg::bank_idx_t    wr_bank;
    gcu_pkg::bank_idx_t    rd_bank;
    logic                  clearing;
    gcu_pkg::sprite_addr_t clear_addr;

    gcu_bus_ctrl #(
        .VRAM_AW (VRAM_AW)
    ) u_bus (
        .CLK96          (CLK96),
        .RESET96        (RESET96),
        .din            (din),
        .op_select_reg  (op_select_reg),
        .op_write_reg   (op_write_reg),
        .op_set_ram_ptr (op_set_ram_ptr),
        .op_write_ram   (op_write_ram),
        .op_read_ram_h  (op_read_ram_h),
        .op_read_ram_l  (op_read_ram_l),
        .ram_rdata      (ram_rdata),
        .dout           (dout),
        .ack            (ack),
        .ram_we         (ram_we),
        .ram_addr       (ram_addr),
        .ram_din        (ram_din),
        .bg_scroll_x    (bg_scroll_x),
        .bg_scroll_y    (bg_scroll_y),
        .fg_scroll_x    (fg_scroll_x),
        .fg_scroll_y    (fg_scroll_y),
        .txt_scroll_x   (txt_scroll_x),
        .txt_scroll_y   (txt_scroll_y),
        .spr_scroll_x   (spr_scroll_x),
        .spr_scroll_y   (spr_scroll_y)
    );

    gcu_sprite_bank_ctrl #(
        .SPRITE_BANK_WORDS (SPRITE_BANK_WORDS)
    ) u_banks (
        .CLK96      (CLK96),
        .RESET96    (RESET96),
        .lvbl       (lvbl),
        .wr_bank    (wr_bank),
        .rd_bank    (rd_bank),
        .clearing   (clearing),
        .clear_addr (clear_addr)
    );

    gcu_vram #(
        .VRAM_AW           (VRAM_AW),
        .SPRITE_BANK_WORDS (SPRITE_BANK_WORDS)
    ) u_vram (
        .CLK96          (CLK96),
        .ram_we         (ram_we),
        .ram_addr       (ram_addr),
        .ram_din        (ram_din),
        .wr_bank        (wr_bank),
        .rd_bank        (rd_bank),
        .clearing       (clearing),
        .clear_addr     (clear_addr),
        .sprite_rd_addr (sprite_rd_addr),
        .ram_rdata      (ram_rdata),
        .sprite_rd_data (sprite_rd_data)
    );

endmodule

//--- test/gcu_checker.sv
`timescale 1ns/100ps

module gcu_checker (
    input  logic           CLK96,
    input  logic           RESET96,
    input  logic           ack,
    input  gcu_pkg::word_t dout,
    input  logic [127:0]   scroll_act,
    input  gcu_pkg::word_t sprite_rd_data,
    input  gcu_pkg::word_t exp_dout,
    input  logic           exp_rd,
    input  int             exp_low,
    input  logic [127:0]   exp_scroll,
    input  gcu_pkg::word_t exp_spr,
    input  logic           spr_chk,
    output int             value_errs,
    output int             ack_errs
);

    logic ack_q;
    int   low_n;

    function automatic string scroll_name(input int i);
        case (i)
            0: return "bg_scroll_x";
            1: return "bg_scroll_y";
            2: return "fg_scroll_x";
            3: return "fg_scroll_y";
            4: return "txt_scroll_x";
            5: return "txt_scroll_y";
            6: return "spr_scroll_x";
            default: return "spr_scroll_y";
        endcase
    endfunction

    initial begin
        value_errs = 0;
        ack_errs = 0;
    end

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge CLK96) begin
        if (RESET96) begin
            ack_q <= 1'b1;
            low_n <= 0;
        end else begin
            ack_q <= ack;
            if (!ack) begin
                low_n <= low_n + 1;
            end else if (!ack_q) begin
                // end of a write or read sequence
                low_n <= 0;
                if (low_n != exp_low) begin
                    $display("** Error at %0t: ack low cycles expected %0d, got %0d",
                             $time, exp_low, low_n);
                    ack_errs++;
                end
                if (exp_rd && dout !== exp_dout) begin
                    $display("** Error at %0t: dout expected %h, got %h",
                             $time, exp_dout, dout);
                    value_errs++;
                end
            end
            for (int i = 0; i < 8; i++) begin
                if (scroll_act[16*i +: 16] !== exp_scroll[16*i +: 16]) begin
                    $display("** Error at %0t: %s expected %h, got %h", $time,
                             scroll_name(i), exp_scroll[16*i +: 16], scroll_act[16*i +: 16]);
                    value_errs++;
                end
            end
            // data for the address driven one cycle earlier
            if (spr_chk && sprite_rd_data !== exp_spr) begin
                $display("** Error at %0t: sprite_rd_data expected %h, got %h",
                         $time, exp_spr, sprite_rd_data);
                value_errs++;
            end
        end
    end

endmodule

//--- test/tb_gcu.sv
`timescale 1ns/100ps

module tb_gcu;

    localparam int B1_N = 20;
    localparam int B2_N = 8;
    localparam int B3_N = 300;
    localparam int B4_N = 32;
    localparam int OPS = 2 * B1_N + 1 + 5 * B2_N + B3_N + 1 + B4_N;
    // worst op is a restarted read, five cycles with the idle gap
    localparam int TEST_CYC = 10 + OPS * 5 + 6 * 1100 + 2 * (B4_N + 2);
    localparam int CYCLE_LIMIT = TEST_CYC * 5 / 4;

    logic           CLK96;
    logic           RESET96;
    logic           lvbl;
    logic [9:0]     sprite_rd_addr;
    gcu_pkg::word_t sprite_rd_data;
    gcu_pkg::word_t din;
    gcu_pkg::word_t dout;
    logic           op_select_reg, op_write_reg, op_set_ram_ptr;
    logic           op_write_ram, op_read_ram_h, op_read_ram_l;
    logic           ack;
    gcu_pkg::word_t bg_x, bg_y, fg_x, fg_y, txt_x, txt_y, spr_x, spr_y;

    // reference model state
    gcu_pkg::word_t vram_img [8192];
    bit             vram_ok [8192];
    gcu_pkg::word_t spr_img [4][1024];
    logic [15:0]    ptr_m;
    logic [7:0]     regsel_m;
    logic [1:0]     wrb_m;

    // expectations handed to the checker
    logic [127:0]   exp_scroll;
    gcu_pkg::word_t exp_dout;
    gcu_pkg::word_t exp_spr;
    logic           exp_rd;
    logic           spr_chk;
    int             exp_low;
    int             value_errs;
    int             ack_errs;
    int             cycles = 0;
    logic [31:0]    lfsr_state = 32'h37bdbf74;

    gcu_top #(
        .VRAM_AW           (13),
        .SPRITE_BANK_WORDS (1024)
    ) u_dut (
        .CLK96 (CLK96), .RESET96 (RESET96), .lvbl (lvbl),
        .sprite_rd_addr (sprite_rd_addr), .sprite_rd_data (sprite_rd_data),
        .din (din), .op_select_reg (op_select_reg), .op_write_reg (op_write_reg),
        .op_set_ram_ptr (op_set_ram_ptr), .op_write_ram (op_write_ram),
        .op_read_ram_h (op_read_ram_h), .op_read_ram_l (op_read_ram_l),
        .dout (dout), .ack (ack),
        .bg_scroll_x (bg_x), .bg_scroll_y (bg_y), .fg_scroll_x (fg_x), .fg_scroll_y (fg_y),
        .txt_scroll_x (txt_x), .txt_scroll_y (txt_y), .spr_scroll_x (spr_x),
        .spr_scroll_y (spr_y)
    );

    gcu_checker u_chk (
        .CLK96 (CLK96), .RESET96 (RESET96), .ack (ack), .dout (dout),
        .scroll_act ({spr_y, spr_x, txt_y, txt_x, fg_y, fg_x, bg_y, bg_x}),
        .sprite_rd_data (sprite_rd_data), .exp_dout (exp_dout), .exp_rd (exp_rd),
        .exp_low (exp_low), .exp_scroll (exp_scroll), .exp_spr (exp_spr),
        .spr_chk (spr_chk), .value_errs (value_errs), .ack_errs (ack_errs)
    );

    initial begin
        CLK96 = 1'b0;
        forever #10 CLK96 = ~CLK96;
    end

    always @(posedge CLK96) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // strobe order: select, write reg, set ptr, write ram, read h, read l
    function automatic int op_cycles(input logic [5:0] m);
        if (m[5:3] != 3'd0) return 1;
        if (m[2]) return 2;
        return 3;
    endfunction

    task automatic drive_strobes(input logic [5:0] m, input gcu_pkg::word_t d);
        {op_select_reg, op_write_reg, op_set_ram_ptr, op_write_ram, op_read_ram_h,
         op_read_ram_l} = m;
        din = d;
    endtask

    // highest priority strobe wins
    task automatic model_op(input logic [5:0] m, input gcu_pkg::word_t d);
        logic [12:0] a;
        exp_rd <= 1'b0;
        if (m[5]) begin
            regsel_m = d[7:0] & 8'h8f;
        end else if (m[4]) begin
            if (regsel_m[6:0] <= 7'd7) exp_scroll[16*regsel_m[2:0] +: 16] <= d;
        end else if (m[3]) begin
            ptr_m = d;
        end else if (m[2]) begin
            a = ptr_m[12:0];
            vram_img[a] = d;
            vram_ok[a] = 1'b1;
            // sprite window mirrors into the current write bank
            if (a >= 13'h1800 && a < 13'h1c00) spr_img[wrb_m][a[9:0]] = d;
            ptr_m = ptr_m + 16'd1;
        end else begin
            a = ptr_m[12:0] + {12'd0, m[0] & ~m[1]};
            exp_rd <= vram_ok[a];
            exp_dout <= vram_img[a];
        end
    endtask

    // called on a falling edge, returns on one; alt replaces a read mid-sequence
    task automatic run_op(input logic [5:0] m, input gcu_pkg::word_t d, input logic [5:0] alt);
        logic [5:0] fin;
        fin = (m[5:2] == 4'd0 && alt != 6'd0) ? alt : m;
        // a replacing op reaches the DUT one cycle later
        if (fin == m) model_op(fin, d);
        exp_low <= (fin != m) ? op_cycles(fin) : op_cycles(m) - 1;
        drive_strobes(m, d);
        @(negedge CLK96);
        if (fin != m) begin
            model_op(fin, d);
            drive_strobes(fin, d);
        end
        while (!ack) @(negedge CLK96);
        drive_strobes(6'd0, d);
        @(negedge CLK96);
    endtask

    task automatic pulse_vblank();
        lvbl = 1'b1;
        wrb_m = wrb_m + 2'd1;
        for (int i = 0; i < 1024; i++) spr_img[wrb_m + 2'd1][i] = '0;
        repeat (8) @(negedge CLK96);
        lvbl = 1'b0;
        // clear sweep is 1024 cycles after the bank switch
        repeat (1040) @(negedge CLK96);
    endtask

    task automatic read_sprites(input int base, input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge CLK96);
            sprite_rd_addr = 10'(base + i);
            exp_spr <= spr_img[wrb_m + 2'd2][10'(base + i)];
            spr_chk <= 1'b1;
        end
        @(negedge CLK96);
        spr_chk <= 1'b0;
    endtask

    initial begin
        logic [5:0]     m;
        logic [5:0]     alt;
        logic [2:0]     kind;
        gcu_pkg::word_t d;
        int             p;
        RESET96 = 1'b1;
        drive_strobes(6'd0, 16'd0);
        lvbl = 1'b0;
        sprite_rd_addr = '0;
        ptr_m = '0;
        regsel_m = 8'hff;
        wrb_m = '0;
        exp_scroll = '0;
        exp_dout = '0;
        exp_spr = '0;
        exp_rd = 1'b0;
        spr_chk = 1'b0;
        exp_low = 0;
        repeat (5) @(negedge CLK96);
        RESET96 = 1'b0;
        @(negedge CLK96);

        // scroll registers, bit 7 of the number is ignored
        for (int n = 0; n < B1_N; n++) begin
            d = {8'(rand_bits(8)), 1'(rand_bits(1)), 3'(rand_bits(3)), 1'b0, 3'(rand_bits(3))};
            run_op(6'b100000, d, 6'd0);
            run_op(6'b010000, 16'(rand_bits(16)), 6'd0);
        end

        // burst write, then read each word back through both read variants
        p = int'(rand_bits(12));
        run_op(6'b001000, 16'(p), 6'd0);
        for (int n = 0; n < B2_N; n++) run_op(6'b000100, 16'(rand_bits(16)), 6'd0);
        for (int n = 0; n < B2_N; n++) begin
            run_op(6'b001000, 16'(p + n), 6'd0);
            run_op(6'b000010, 16'd0, 6'd0);
            run_op(6'b001000, 16'(p + n - 1), 6'd0);
            run_op(6'b000001, 16'd0, 6'd0);
        end

        // random mix, pointer kept near the sprite window edge
        for (int n = 0; n < B3_N; n++) begin
            kind = 3'(rand_bits(3));
            d = 16'(rand_bits(16));
            alt = 6'd0;
            case (kind)
                3'd0: m = 6'b100000;
                3'd1: m = 6'b010000;
                3'd2: begin
                    m = 6'b001000;
                    d = 16'h17e0 + 16'(rand_bits(6));
                end
                3'd3, 3'd4: m = 6'b000100;
                default: m = rand_bits(1) ? 6'b000010 : 6'b000001;
            endcase
            if (kind == 3'd7) alt = 6'(rand_bits(6));
            // extra lower priority strobes that must lose
            if (rand_bits(2) == 0) m = m | (6'(rand_bits(6)) & (m - 6'd1));
            run_op(m, d, alt);
        end

        // sprite bank rotation and clear
        p = int'(rand_bits(9));
        run_op(6'b001000, 16'h1800 + 16'(p), 6'd0);
        for (int n = 0; n < B4_N; n++) run_op(6'b000100, 16'(rand_bits(16)), 6'd0);
        pulse_vblank();
        pulse_vblank();
        read_sprites(p, B4_N);
        // bank k is swept on the third edge and reaches the renderer again on the sixth
        repeat (4) pulse_vblank();
        read_sprites(p, B4_N);

        repeat (2) @(negedge CLK96);
        $display("errors: value %0d, ack timing %0d", value_errs, ack_errs);
        if (value_errs == 0 && ack_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
source/gcu_pkg.sv
source/gcu_bus_ctrl.sv
source/gcu_sprite_bank_ctrl.sv
source/gcu_vram.sv
source/gcu_top.sv
test/gcu_checker.sv
test/tb_gcu.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_gcu \
    -o sim_gcu --Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/sim_gcu > sim.log 2>&1 \
    || { echo "build or run failed"; exit 1; }
grep -q "^sim passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
